//--- hw/cmd_deserializer.sv
`timescale 1ns/100ps

module cmd_deserializer import sd_cmd_pkg::*; (
	input  logic       sd_clock,
	input  logic       rst_n,
	input  logic       rx_arm,
	input  frame_len_t rx_len,
	input  logic       pin_in,
	output logic       rx_done,
	output response_t  rx_data,
	output logic       start_seen
);

	typedef enum logic [1:0] {
		rx_hunt,
		rx_shift,
		rx_hold
	} rx_state_t;

	rx_state_t  state;
	frame_len_t bit_cnt;  // bits taken so far, start bit included
	response_t  shift_q;

	assign rx_data    = shift_q;
	assign start_seen = (state != rx_hunt);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			state   <= rx_hunt;
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (!rx_arm) begin
				state   <= rx_hunt;
				bit_cnt <= '0;
			end else begin
				case (state)
					rx_hunt: if (!pin_in) begin
						state   <= rx_shift;
						bit_cnt <= 8'd1;
					end
					rx_shift: begin
						bit_cnt <= bit_cnt + 8'd1;
						if (bit_cnt == rx_len - 8'd1) begin
							state   <= rx_hold;
							rx_done <= 1'b1;
						end
					end
					default: ;  // wait for disarm
				endcase
			end
		end
	end

	// right aligned, upper bits stay zero for short frames
	always_ff @(posedge sd_clock) begin
		if (rx_arm && state == rx_hunt && !pin_in)
			shift_q <= '0;
		else if (rx_arm && state == rx_shift)
			shift_q <= {shift_q[134:0], pin_in};
	end

endmodule

//--- hw/cmd_pad.sv
`timescale 1ns/100ps

module cmd_pad (
	input  logic sd_clock,
	input  logic rst_n,
	input  logic drive_en,
	input  logic drive_bit,
	output logic pin_in,
	inout  wire  cmd_pin
);

	logic out_q;
	logic oe_q;

	// line is released unless we own it
	assign cmd_pin = oe_q ? out_q : 1'bz;

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			oe_q   <= 1'b0;
			pin_in <= 1'b1;  // idle line level
		end else begin
			oe_q   <= drive_en;
			pin_in <= cmd_pin;
		end
	end

	always_ff @(posedge sd_clock) begin
		out_q <= drive_bit;
	end

endmodule

//--- hw/cmd_phys.sv
`timescale 1ns/100ps

module cmd_phys import sd_cmd_pkg::*; #(
	parameter int resp_timeout = 64
) (
	input  logic        sd_clock,
	input  logic        rst_n,
	// host
	input  logic        strobe_in,   // new command
	input  logic        ack_in,      // response taken
	input  logic        idle_in,     // abort
	input  cmd_fields_t cmd_to_send,
	output logic        ack_out,
	output logic        strobe_out,  // response valid
	output logic        timeout_out,
	output response_t   response,
	// card side
	inout  wire         cmd_pin
);

	logic        load;
	cmd_fields_t cmd;
	logic        ser_bit;
	logic        ser_done;
	logic        rx_arm;
	frame_len_t  rx_len;
	logic        rx_done;
	response_t   rx_data;
	logic        start_seen;
	logic        drive_en;
	logic        pin_in;

	cmd_phys_controller #(
		.resp_timeout(resp_timeout)
	) u_controller (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.strobe_in   (strobe_in),
		.ack_in      (ack_in),
		.idle_in     (idle_in),
		.cmd_to_send (cmd_to_send),
		.ack_out     (ack_out),
		.strobe_out  (strobe_out),
		.timeout_out (timeout_out),
		.response    (response),
		.load        (load),
		.cmd         (cmd),
		.ser_done    (ser_done),
		.rx_arm      (rx_arm),
		.rx_len      (rx_len),
		.rx_done     (rx_done),
		.rx_data     (rx_data),
		.start_seen  (start_seen),
		.drive_en    (drive_en)
	);

	cmd_serializer u_serializer (
		.sd_clock (sd_clock),
		.rst_n    (rst_n),
		.load     (load),
		.cmd      (cmd),
		.ser_bit  (ser_bit),
		.ser_done (ser_done)
	);

	cmd_deserializer u_deserializer (
		.sd_clock   (sd_clock),
		.rst_n      (rst_n),
		.rx_arm     (rx_arm),
		.rx_len     (rx_len),
		.pin_in     (pin_in),
		.rx_done    (rx_done),
		.rx_data    (rx_data),
		.start_seen (start_seen)
	);

	cmd_pad u_pad (
		.sd_clock  (sd_clock),
		.rst_n     (rst_n),
		.drive_en  (drive_en),
		.drive_bit (ser_bit),
		.pin_in    (pin_in),
		.cmd_pin   (cmd_pin)
	);

endmodule

//--- hw/cmd_phys_controller.sv
`timescale 1ns/100ps

module cmd_phys_controller import sd_cmd_pkg::*; #(
	parameter int resp_timeout = 64
) (
	input  logic        sd_clock,
	input  logic        rst_n,
	// host side
	input  logic        strobe_in,
	input  logic        ack_in,
	input  logic        idle_in,
	input  cmd_fields_t cmd_to_send,
	output logic        ack_out,
	output logic        strobe_out,
	output logic        timeout_out,
	output response_t   response,
	// serializer
	output logic        load,
	output cmd_fields_t cmd,
	input  logic        ser_done,
	// deserializer
	output logic        rx_arm,
	output frame_len_t  rx_len,
	input  logic        rx_done,
	input  response_t   rx_data,
	input  logic        start_seen,
	// pad
	output logic        drive_en
);

	typedef enum logic [1:0] {
		idle,
		send,
		listen,
		deliver
	} ctl_state_t;

	// our own end bit is still in the pad and input pipeline for two cycles
	localparam int turnaround = 2;
	localparam int wait_w     = $clog2(resp_timeout + turnaround + 1);

	localparam logic [wait_w-1:0] arm_point = wait_w'(turnaround);
	localparam logic [wait_w-1:0] wait_last = wait_w'(resp_timeout + turnaround - 1);

	ctl_state_t        state;
	cmd_fields_t       cmd_q;
	logic [wait_w-1:0] wait_cnt;

	assign cmd    = cmd_q;
	assign rx_len = frame_len_for(cmd_q.index);

	// first send cycle is the load cycle, serializer has no bit yet
	assign drive_en = (state == send) && !load;
	assign rx_arm   = (state == listen) && (wait_cnt >= arm_point);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			state       <= idle;
			ack_out     <= 1'b0;
			load        <= 1'b0;
			strobe_out  <= 1'b0;
			timeout_out <= 1'b0;
			response    <= '0;
			wait_cnt    <= '0;
		end else begin
			ack_out     <= 1'b0;
			load        <= 1'b0;
			timeout_out <= 1'b0;
			if (idle_in) begin
				state      <= idle;  // abort, pin released via drive_en
				strobe_out <= 1'b0;
			end else begin
				case (state)
					idle: begin
						if (strobe_in) begin
							ack_out <= 1'b1;
							load    <= 1'b1;
							state   <= send;
						end
					end
					send: begin
						if (ser_done) begin
							wait_cnt <= '0;
							if (rx_len == 8'd0)
								state <= idle;  // cmd0, nothing comes back
							else
								state <= listen;
						end
					end
					listen: begin
						if (rx_done) begin
							response   <= rx_data;
							strobe_out <= 1'b1;
							state      <= deliver;
						end else if (!start_seen) begin
							if (wait_cnt == wait_last) begin
								timeout_out <= 1'b1;
								state       <= idle;
							end else begin
								wait_cnt <= wait_cnt + 1'b1;
							end
						end
					end
					deliver: begin
						// hold response until the host takes it
						if (ack_in) begin
							strobe_out <= 1'b0;
							state      <= idle;
						end
					end
					default: state <= idle;
				endcase
			end
		end
	end

	// command latched on acceptance, stable while it is shifted out
	always_ff @(posedge sd_clock) begin
		if (state == idle && strobe_in && !idle_in)
			cmd_q <= cmd_to_send;
	end

endmodule

//--- hw/cmd_serializer.sv
`timescale 1ns/100ps

module cmd_serializer import sd_cmd_pkg::*; (
	input  logic        sd_clock,
	input  logic        rst_n,
	input  logic        load,
	input  cmd_fields_t cmd,
	output logic        ser_bit,
	output logic        ser_done
);

	logic [47:0] shift_q;
	logic [5:0]  bit_cnt;   // index of the frame bit now on ser_bit
	logic        active;
	crc7_t       crc;
	crc7_t       crc_next;
	logic        crc_fb;

	// x^7 + x^3 + 1, fed with the bit currently presented
	assign crc_fb   = shift_q[47] ^ crc[6];
	assign crc_next = {crc[5:0], 1'b0} ^ ({7{crc_fb}} & 7'h09);

	assign ser_bit  = shift_q[47];
	assign ser_done = active && (bit_cnt == 6'd0);

	always_ff @(posedge sd_clock) begin
		if (!rst_n) begin
			active  <= 1'b0;
			bit_cnt <= 6'd0;
			crc     <= '0;
		end else if (load) begin
			active  <= 1'b1;
			bit_cnt <= 6'd47;
			crc     <= '0;
		end else if (active) begin
			bit_cnt <= bit_cnt - 6'd1;
			if (bit_cnt == 6'd0)
				active <= 1'b0;
			if (bit_cnt >= 6'd8)
				crc <= crc_next;  // only the 40 command bits count
		end
	end

	// shifter; tail is replaced by crc and end bit after bit 8
	always_ff @(posedge sd_clock) begin
		if (load) begin
			shift_q <= {cmd, 8'h01};
		end else if (active) begin
			if (bit_cnt == 6'd8)
				shift_q <= {crc_next, 1'b1, 40'd0};
			else
				shift_q <= {shift_q[46:0], 1'b0};
		end
	end

endmodule

//--- hw/sd_cmd_pkg.sv
package sd_cmd_pkg;

	// widths that carry a meaning on the command line
	typedef logic [5:0]   cmd_index_t;
	typedef logic [31:0]  cmd_arg_t;
	typedef logic [6:0]   crc7_t;
	typedef logic [7:0]   frame_len_t;
	typedef logic [135:0] response_t;

	// host command word, sent MSB first
	typedef struct packed {
		logic       start_bit;  // always 0 on the wire
		logic       trans_bit;  // 1 = host to card
		cmd_index_t index;
		cmd_arg_t   arg;
	} cmd_fields_t;

	localparam frame_len_t long_frame_len  = 8'd136;
	localparam frame_len_t short_frame_len = 8'd48;

	// R2 (cmd2, cmd9, cmd10) is long, cmd0 has no reply
	function automatic frame_len_t frame_len_for(input cmd_index_t index);
		case (index)
			6'd2, 6'd9, 6'd10: begin
				return long_frame_len;
			end
			6'd0: begin
				return 8'd0;
			end
			default: begin
				return short_frame_len;
			end
		endcase
	endfunction

endpackage

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cmd_phys_tb -f vlog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vcmd_phys_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TEST OK$"; then
	exit 0
fi
echo "pass message not found"
exit 1

//--- testbench/cmd_phys_checker.sv
`timescale 1ns/100ps

module cmd_phys_checker (
	input logic sd_clock,
	input logic rst_n,
	input logic ack_in,
	input logic idle_in,
	input logic ack_out,
	input logic strobe_out,
	input logic timeout_out,
	input logic drive_en,
	input logic rx_arm
);

	int fail_cnt = 0;  // read by the testbench at the end

	ack_one_cycle: assert property (@(posedge sd_clock) disable iff (!rst_n)
		ack_out |=> !ack_out)
		else begin
			$error("ack_out held high for two cycles");
			fail_cnt++;
		end

	timeout_one_cycle: assert property (@(posedge sd_clock) disable iff (!rst_n)
		timeout_out |=> !timeout_out)
		else begin
			$error("timeout_out held high for two cycles");
			fail_cnt++;
		end

	// only ack_in or an abort may take the response away
	strobe_held: assert property (@(posedge sd_clock) disable iff (!rst_n)
		strobe_out && !ack_in && !idle_in |=> strobe_out)
		else begin
			$error("strobe_out dropped without ack_in");
			fail_cnt++;
		end

	// pad and input register still carry our own last bit for two cycles
	no_drive_while_armed: assert property (@(posedge sd_clock) disable iff (!rst_n)
		rx_arm |-> !drive_en && !$past(drive_en) && !$past(drive_en, 2))
		else begin
			$error("receiver armed while own frame still on the line");
			fail_cnt++;
		end

	no_strobe_with_ack: assert property (@(posedge sd_clock) disable iff (!rst_n)
		!(strobe_out && ack_out))
		else begin
			$error("strobe_out and ack_out high together");
			fail_cnt++;
		end

endmodule

//--- testbench/cmd_phys_tb.sv
`timescale 1ns/100ps

module cmd_phys_tb import sd_cmd_pkg::*; ();

	localparam int         clk_period = 40;
	localparam int         n_tests    = 11;
	localparam logic [7:0] rnd        = 8'hff;  // delay picked with $urandom

	typedef struct packed {
		cmd_index_t idx;
		cmd_arg_t   arg;
		logic       replies;
		logic [7:0] reply_delay;  // abort point when the card stays silent
		logic [7:0] ack_delay;
		logic       abort;
	} test_row_t;

	logic        sd_clock;
	logic        rst_n;
	logic        strobe_in;
	logic        ack_in;
	logic        idle_in;
	cmd_fields_t cmd_to_send;
	logic        ack_out;
	logic        strobe_out;
	logic        timeout_out;
	response_t   response;
	wire         cmd_pin;
	logic        card_oe;
	logic        card_bit;

	test_row_t table_q [n_tests];
	int errors      = 0;
	int ack_cnt     = 0;
	int timeout_cnt = 0;
	int strobe_cnt  = 0;

	assign cmd_pin = card_oe ? card_bit : 1'bz;  // card side of the line
	pullup (cmd_pin);

	cmd_phys #(
		.resp_timeout(64)
	) u_cmd_phys (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.strobe_in   (strobe_in),
		.ack_in      (ack_in),
		.idle_in     (idle_in),
		.cmd_to_send (cmd_to_send),
		.ack_out     (ack_out),
		.strobe_out  (strobe_out),
		.timeout_out (timeout_out),
		.response    (response),
		.cmd_pin     (cmd_pin)
	);

	bind cmd_phys cmd_phys_checker u_checker (
		.sd_clock    (sd_clock),
		.rst_n       (rst_n),
		.ack_in      (ack_in),
		.idle_in     (idle_in),
		.ack_out     (ack_out),
		.strobe_out  (strobe_out),
		.timeout_out (timeout_out),
		.drive_en    (drive_en),
		.rx_arm      (rx_arm)
	);

	initial begin
		sd_clock = 1'b0;
		forever #(clk_period / 2) sd_clock = ~sd_clock;
	end

	initial begin
		#(n_tests * 400 * clk_period);
		$display("watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	// event counters, read as differences per test
	always @(posedge sd_clock) begin
		if (ack_out)
			ack_cnt <= ack_cnt + 1;
		if (timeout_out)
			timeout_cnt <= timeout_cnt + 1;
		if (strobe_out)
			strobe_cnt <= strobe_cnt + 1;
	end

	// x^7 + x^3 + 1 over the 40 command bits, msb first
	function automatic crc7_t crc7_of(input logic [39:0] bits);
		crc7_t crc;
		logic  fb;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			fb  = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
		end
		return crc;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			$display("CHECK FAILED at %0t ns: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic next_cycle();
		@(posedge sd_clock);
		#2;
	endtask

	task automatic run_test(input int t, input test_row_t row);
		cmd_fields_t cmd;
		logic [47:0] frame;
		logic [47:0] expect_frame;
		response_t   reply;
		response_t   held;
		int          len;
		int          delay;
		int          ack_delay;
		int          ack_base;
		int          to_base;
		int          strobe_base;
		int          err_base;
		int          n;
		len       = (row.idx == 2 || row.idx == 9 || row.idx == 10) ? 136 : (row.idx == 0 ? 0 : 48);
		delay     = (row.reply_delay == rnd) ? int'($urandom % 40) : int'(row.reply_delay);
		ack_delay = (row.ack_delay == rnd) ? int'($urandom % 12) : int'(row.ack_delay);
		reply     = '0;
		repeat (5) reply = (reply << 32) | response_t'($urandom);
		if (len == 48)
			reply[135:48] = '0;
		if (len > 0)
			reply[len-1] = 1'b0;  // start bit
		reply[0]     = 1'b1;      // end bit
		cmd          = '{start_bit: 1'b0, trans_bit: 1'b1, index: row.idx, arg: row.arg};
		expect_frame = {cmd, crc7_of(cmd), 1'b1};
		ack_base     = ack_cnt;
		to_base      = timeout_cnt;
		strobe_base  = strobe_cnt;
		err_base     = errors;

		cmd_to_send = cmd;
		strobe_in   = 1'b1;
		n = 0;
		while (ack_out !== 1'b1 && n < 8) begin
			@(negedge sd_clock);
			n++;
		end
		if (ack_out !== 1'b1)
			report_problem($sformatf("test %0d: the command was never acknowledged", t));
		next_cycle();
		strobe_in = 1'b0;

		// card side: hunt for the start bit, then take 48 bits
		n = 0;
		while (cmd_pin !== 1'b0 && n < 8) begin
			@(negedge sd_clock);
			n++;
		end
		for (int i = 0; i < 48; i++) begin
			if (i > 0)
				@(negedge sd_clock);
			frame = {frame[46:0], cmd_pin};
		end
		check(frame === expect_frame,
			$sformatf("test %0d: frame %h, expected %h", t, frame, expect_frame));

		if (row.replies) begin
			repeat (delay + 1) @(posedge sd_clock);
			#2;
			card_bit = reply[len-1];
			card_oe  = 1'b1;
			for (int i = len - 1; i >= 0; i--) begin
				card_bit = reply[i];
				next_cycle();
			end
			card_oe = 1'b0;
			n = 0;
			while (strobe_out !== 1'b1 && n < 10) begin
				@(negedge sd_clock);
				n++;
			end
			check(strobe_out === 1'b1, $sformatf("test %0d: strobe_out never rose", t));
			check(response === reply,
				$sformatf("test %0d: response %h, expected %h", t, response, reply));
			held = response;
			repeat (ack_delay) begin
				@(negedge sd_clock);
				check(strobe_out === 1'b1 && response === held,
					$sformatf("test %0d: response not held before ack_in", t));
			end
			next_cycle();
			ack_in = 1'b1;
			next_cycle();
			ack_in = 1'b0;
			@(negedge sd_clock);
			check(strobe_out === 1'b0, $sformatf("test %0d: strobe_out stuck after ack_in", t));
		end else begin
			if (row.abort) begin
				repeat (delay) next_cycle();
				idle_in = 1'b1;  // abort while listening
				next_cycle();
				idle_in = 1'b0;
			end
			repeat (90) @(negedge sd_clock);
			check(cmd_pin === 1'b1, $sformatf("test %0d: cmd_pin not released", t));
			check(strobe_cnt == strobe_base, $sformatf("test %0d: unexpected strobe_out", t));
		end
		check(ack_cnt - ack_base == 1, $sformatf("test %0d: ack_out count wrong", t));
		check(timeout_cnt - to_base == ((!row.replies && len != 0 && !row.abort) ? 1 : 0),
			$sformatf("test %0d: timeout_out count wrong", t));
		$display("test %0d index %0d: %s", t, row.idx, (errors == err_base) ? "pass" : "fail");
	endtask

	initial begin
		void'($urandom(32'hbcea_bea4));
		rst_n       = 1'b0;
		strobe_in   = 1'b0;
		ack_in      = 1'b0;
		idle_in     = 1'b0;
		cmd_to_send = '0;
		card_oe     = 1'b0;
		card_bit    = 1'b1;
		table_q[0]  = '{6'd0,  32'h0000_0000, 1'b0, 8'd0,  8'd0, 1'b0};  // no reply
		table_q[1]  = '{6'd8,  32'h0000_01aa, 1'b1, 8'd3,  8'd2, 1'b0};
		table_q[2]  = '{6'd2,  32'h0000_0000, 1'b1, rnd,   rnd,  1'b0};  // long
		table_q[3]  = '{6'd17, 32'h0000_0200, 1'b1, rnd,   rnd,  1'b0};
		table_q[4]  = '{6'd9,  32'h1234_0000, 1'b1, 8'd0,  8'd5, 1'b0};
		table_q[5]  = '{6'd13, 32'h5678_0000, 1'b0, 8'd0,  8'd0, 1'b0};  // timeout
		table_q[6]  = '{6'd10, 32'habcd_0000, 1'b1, rnd,   rnd,  1'b0};
		table_q[7]  = '{6'd55, 32'h0000_0000, 1'b0, 8'd10, 8'd0, 1'b1};  // abort
		table_q[8]  = '{6'd16, 32'h0000_0200, 1'b1, 8'd12, 8'd0, 1'b0};
		table_q[9]  = '{6'd0,  32'h0000_0000, 1'b0, 8'd0,  8'd0, 1'b0};
		table_q[10] = '{6'd41, 32'h40ff_8000, 1'b1, rnd,   rnd,  1'b0};

		// known frames, cmd0 ends in 0x95 and cmd8 in 0x87
		check(crc7_of(40'h40_0000_0000) == 7'h4a, "crc7 of cmd0 is not 0x4a");
		check(crc7_of(40'h48_0000_01aa) == 7'h43, "crc7 of cmd8 is not 0x43");

		repeat (16) @(posedge sd_clock);
		#2;
		rst_n = 1'b1;
		@(negedge sd_clock);
		check(!ack_out && !strobe_out && !timeout_out && response === '0,
			"outputs not cleared by reset");
		for (int t = 0; t < n_tests; t++) begin
			next_cycle();
			run_test(t, table_q[t]);
		end
		errors += u_cmd_phys.u_checker.fail_cnt;
		$display("%0d tests run, %0d errors", n_tests, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vlog.f
hw/sd_cmd_pkg.sv
hw/cmd_serializer.sv
hw/cmd_deserializer.sv
hw/cmd_pad.sv
hw/cmd_phys_controller.sv
hw/cmd_phys.sv
testbench/cmd_phys_checker.sv
testbench/cmd_phys_tb.sv
